/* bench/wb_trace.txt */
# I pc inst result dmem_rdata gap : hex words, gap in idle cycles after the strobe
# C reg value : register number in decimal, expected value in hex
# addi x1, add x2, lui x3, auipc x4
I 00000100 00a00093 0000000a deadbeef 0
I 00000104 00108133 00000014 deadbeef 1
I 00000108 123451b7 12345000 00000000 0
I 0000010c 00001217 0000110c 00000000 2
# lw x5 takes dmem_rdata, not the address in result
I 00000110 00012283 00000014 cafef00d 0
# jal x6 and jalr x7 link pc+4
I 00000114 0080036f 0000011c 00000000 0
I 00000118 000083e7 0000000a 00000000 1
C 1 0000000a
C 2 00000014
C 3 12345000
C 4 0000110c
C 5 cafef00d
C 6 00000118
C 7 0000011c
# sw with rd field 4, beq with rd field 8, csrrw x9
I 0000011c 0020a223 0000000e 55555555 0
I 00000120 00208463 00000099 00000000 0
I 00000124 300094f3 00000077 00000000 1
C 4 0000110c
C 8 00000000
C 9 00000000
C 2 00000014
# addi x0 retires and is dropped
I 00000128 00500013 00000005 00000000 0
C 0 00000000
# Back-to-back strobes, x10 written three times
I 0000012c 00100513 00000001 00000000 0
I 00000130 00200513 00000002 00000000 0
I 00000134 0005a583 00000000 0badf00d 0
I 00000138 00300513 00000003 00000000 0
C 10 00000003
C 11 0badf00d
C 1 0000000a
C 0 00000000

/* verilog.f */
common/wb_pkg.sv
rtl/mem_wb_latch.sv
wbu/wb_ctrl.sv
wbu/wbu.sv
rtl/reg_file.sv
rtl/wb_backend_top.sv
bench/wb_backend_props.sv
bench/wb_backend_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = wb_backend_tb
FILELIST  = verilog.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

# Pass or fail comes from the log, not from the simulator exit code
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/wb_backend_tb.sv */
module wb_backend_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REGS = 32;

    logic              clk;
    logic              rst_i;
    logic              mem_valid_i;
    wb_pkg::mem_wb_t   mem_bundle_i;
    wb_pkg::reg_addr_t rs1_addr_i;
    wb_pkg::reg_addr_t rs2_addr_i;
    wb_pkg::xlen_t     rs1_data_o;
    wb_pkg::xlen_t     rs2_data_o;
    logic              retire_o;
    wb_pkg::xlen_t     retire_pc_o;

    // Trace operations in file order, unused fields hold zero
    byte               op_kind [$];
    wb_pkg::mem_wb_t   op_bundle [$];
    int                op_gap [$];
    wb_pkg::reg_addr_t op_reg [$];
    wb_pkg::xlen_t     op_val [$];

    int                issue_cnt = 0;
    int                retire_cnt = 0;
    int                cycle_cnt = 0;
    int                cycle_limit = 0;
    logic              need_settle = 1'b0;

    // Strobe as seen by the latch at the last rising edge
    logic              exp_valid = 1'b0;
    wb_pkg::xlen_t     exp_pc = '0;

    wb_backend_top #(
        .NUM_REGS (NUM_REGS)
    ) wb_backend_top_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .mem_valid_i  (mem_valid_i),
        .mem_bundle_i (mem_bundle_i),
        .rs1_addr_i   (rs1_addr_i),
        .rs2_addr_i   (rs2_addr_i),
        .rs1_data_o   (rs1_data_o),
        .rs2_data_o   (rs2_data_o),
        .retire_o     (retire_o),
        .retire_pc_o  (retire_pc_o)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_retire(input wb_pkg::xlen_t exp_pc_val);
        if (retire_o !== 1'b1) begin
            report_mismatch($sformatf("retire_o low one cycle after strobe of pc %h",
                                      exp_pc_val));
        end else if (retire_pc_o !== exp_pc_val) begin
            report_mismatch($sformatf("retire_pc_o is %h, expected %h",
                                      retire_pc_o, exp_pc_val));
        end
    endtask

    // Both read ports look at the same register
    task automatic check_reg(input wb_pkg::reg_addr_t addr, input wb_pkg::xlen_t exp_val);
        rs1_addr_i = addr;
        rs2_addr_i = addr;
        #1;
        if (rs1_data_o !== exp_val) begin
            report_mismatch($sformatf("x%0d on read port 1 is %h, expected %h",
                                      addr, rs1_data_o, exp_val));
        end else if (rs2_data_o !== exp_val) begin
            report_mismatch($sformatf("x%0d on read port 2 is %h, expected %h",
                                      addr, rs2_data_o, exp_val));
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        mem_valid_i = 1'b0;
    endtask

    // Strobe is sampled at the next rising edge
    task automatic issue_inst(input wb_pkg::mem_wb_t bundle, input int gap);
        @(posedge clk);
        #1;
        mem_valid_i  = 1'b1;
        mem_bundle_i = bundle;
        issue_cnt++;
        need_settle = 1'b1;
        repeat (gap) idle_cycle();
    endtask

    task automatic run_op(input int k);
        if (op_kind[k] == "I") begin
            issue_inst(op_bundle[k], op_gap[k]);
        end else begin
            if (need_settle) begin
                // Strobe edge, then the edge where the write lands
                idle_cycle();
                idle_cycle();
                need_settle = 1'b0;
            end
            check_reg(op_reg[k], op_val[k]);
        end
    endtask

    task automatic load_trace();
        int               fd;
        int               code;
        int               units;
        int               gap;
        int               reg_num;
        byte              tag;
        logic [8*128-1:0] skip_line;
        wb_pkg::xlen_t    f_pc;
        wb_pkg::xlen_t    f_inst;
        wb_pkg::xlen_t    f_result;
        wb_pkg::xlen_t    f_rdata;
        wb_pkg::xlen_t    val;
        wb_pkg::mem_wb_t  b;
        fd = $fopen("bench/wb_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file bench/wb_trace.txt");
            abort_run();
        end else begin
            units = 0;
            while ($fscanf(fd, " %c", tag) == 1) begin
                if (tag == "#") begin
                    code = $fgets(skip_line, fd);
                end else if (tag == "I") begin
                    code = $fscanf(fd, "%h %h %h %h %d", f_pc, f_inst, f_result, f_rdata, gap);
                    if (code != 5) begin
                        $display("Malformed issue line in the trace file");
                        abort_run();
                    end
                    b.pc         = f_pc;
                    b.inst       = f_inst;
                    b.result     = f_result;
                    b.dmem_rdata = f_rdata;
                    op_kind.push_back("I");
                    op_bundle.push_back(b);
                    op_gap.push_back(gap);
                    op_reg.push_back('0);
                    op_val.push_back('0);
                    units = units + 1 + gap;
                end else if (tag == "C") begin
                    code = $fscanf(fd, "%d %h", reg_num, val);
                    if (code != 2) begin
                        $display("Malformed check line in the trace file");
                        abort_run();
                    end
                    op_kind.push_back("C");
                    op_bundle.push_back('0);
                    op_gap.push_back(0);
                    op_reg.push_back(wb_pkg::reg_addr_t'(reg_num));
                    op_val.push_back(val);
                    units = units + 1;
                end else begin
                    $display("Unknown line type in the trace file");
                    abort_run();
                end
            end
            $fclose(fd);
            cycle_limit = units * 2 + 50;
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    always @(posedge clk) begin
        exp_valid <= mem_valid_i;
        exp_pc    <= mem_bundle_i.pc;
    end

    // Retire pulse sits between two rising edges, sample it at the falling one
    always @(negedge clk) begin
        if (retire_o === 1'b1) begin
            retire_cnt = retire_cnt + 1;
        end
        if (exp_valid) begin
            check_retire(exp_pc);
        end else if (retire_o !== 1'b0) begin
            $display("Retire pulse at %0d ns with no instruction issued", $time);
            abort_run();
        end
    end

    initial begin
        clk          = 1'b0;
        rst_i        = 1'b1;
        mem_valid_i  = 1'b0;
        mem_bundle_i = '0;
        rs1_addr_i   = '0;
        rs2_addr_i   = '0;
        load_trace();
        repeat (4) @(posedge clk);
        #1;
        rst_i = 1'b0;

        // Cleared register file, and no retire while idle
        for (int i = 0; i < NUM_REGS; i++) begin
            check_reg(wb_pkg::reg_addr_t'(i), '0);
        end
        repeat (4) idle_cycle();

        foreach (op_kind[k]) begin
            run_op(k);
        end
        repeat (3) idle_cycle();

        if (retire_cnt != issue_cnt) begin
            $display("Saw %0d retire pulses for %0d issued instructions",
                     retire_cnt, issue_cnt);
            abort_run();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* bench/wb_backend_props.sv */
// Timing checks on the write-back unit
module wb_backend_props (
    input logic          clk,
    input logic          rf_we_o,
    input logic          retire_o,
    input wb_pkg::xlen_t retire_pc_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // A register write is always part of a retiring instruction
    we_implies_retire: assert property (@(posedge clk) rf_we_o |-> retire_o)
        else $error("rf_we_o high without retire_o");

    // The held pc only moves when a new instruction retires
    retire_pc_held: assert property (@(posedge clk)
        (!retire_o && !$isunknown($past(retire_pc_o))) |-> $stable(retire_pc_o))
        else $error("retire_pc_o changed in a cycle without retire_o");

endmodule

bind wbu wb_backend_props wb_backend_props_inst (
    .clk         (clk),
    .rf_we_o     (rf_we_o),
    .retire_o    (retire_o),
    .retire_pc_o (retire_pc_o)
);

/* rtl/wb_backend_top.sv */
// Write-back back end
// Input latch, write-back unit and register file
module wb_backend_top #(
    // 16 gives RV32E
    parameter int NUM_REGS = 32
) (
    input  logic              clk,
    input  logic              rst_i,

    // Memory stage side
    input  logic              mem_valid_i,
    input  wb_pkg::mem_wb_t   mem_bundle_i,

    // Register read ports
    input  wb_pkg::reg_addr_t rs1_addr_i,
    input  wb_pkg::reg_addr_t rs2_addr_i,
    output wb_pkg::xlen_t     rs1_data_o,
    output wb_pkg::xlen_t     rs2_data_o,

    // Retire pulse to fetch
    output logic              retire_o,
    output wb_pkg::xlen_t     retire_pc_o
);

    logic              wb_valid;
    wb_pkg::mem_wb_t   wb_bundle;

    logic              rf_we;
    wb_pkg::reg_addr_t rf_waddr;
    wb_pkg::xlen_t     rf_wdata;

    mem_wb_latch mem_wb_latch_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .mem_valid_i  (mem_valid_i),
        .mem_bundle_i (mem_bundle_i),
        .wb_valid_o   (wb_valid),
        .wb_bundle_o  (wb_bundle)
    );

    wbu wbu_inst (
        .clk         (clk),
        .wb_valid_i  (wb_valid),
        .wb_bundle_i (wb_bundle),
        .rf_we_o     (rf_we),
        .rf_waddr_o  (rf_waddr),
        .rf_wdata_o  (rf_wdata),
        .retire_o    (retire_o),
        .retire_pc_o (retire_pc_o)
    );

    reg_file #(
        .NUM_REGS (NUM_REGS)
    ) reg_file_inst (
        .clk      (clk),
        .rst_i    (rst_i),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr1_i (rs1_addr_i),
        .raddr2_i (rs2_addr_i),
        .rdata1_o (rs1_data_o),
        .rdata2_o (rs2_data_o)
    );

endmodule

/* rtl/reg_file.sv */
// Integer register file
// One synchronous write port, two asynchronous read ports, x0 hardwired to zero
module reg_file #(
    parameter int NUM_REGS = 32
) (
    input  logic              clk,
    input  logic              rst_i,

    // Write port
    input  logic              we_i,
    input  wb_pkg::reg_addr_t waddr_i,
    input  wb_pkg::xlen_t     wdata_i,

    // Read ports
    input  wb_pkg::reg_addr_t raddr1_i,
    input  wb_pkg::reg_addr_t raddr2_i,
    output wb_pkg::xlen_t     rdata1_o,
    output wb_pkg::xlen_t     rdata2_o
);

    wb_pkg::xlen_t regs [NUM_REGS];

    logic waddr_ok;
    logic raddr1_ok;
    logic raddr2_ok;

    // x0 and registers beyond NUM_REGS (RV32E) are never touched
    assign waddr_ok  = (waddr_i != '0) && (int'(waddr_i) < NUM_REGS);
    assign raddr1_ok = (raddr1_i != '0) && (int'(raddr1_i) < NUM_REGS);
    assign raddr2_ok = (raddr2_i != '0) && (int'(raddr2_i) < NUM_REGS);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_ok) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // No bypass, a same-cycle write shows up after the edge
    assign rdata1_o = raddr1_ok ? regs[raddr1_i] : '0;
    assign rdata2_o = raddr2_ok ? regs[raddr2_i] : '0;

endmodule

/* wbu/wbu.sv */
// Write-back unit
// Picks the register write value and signals retirement to fetch
module wbu (
    // Only sampled by bound checks, datapath is combinational
    input  logic             clk,

    // From the input latch
    input  logic             wb_valid_i,
    input  wb_pkg::mem_wb_t  wb_bundle_i,

    // Register file write port
    output logic             rf_we_o,
    output wb_pkg::reg_addr_t rf_waddr_o,
    output wb_pkg::xlen_t    rf_wdata_o,

    // Retire info for the fetch stage
    output logic             retire_o,
    output wb_pkg::xlen_t    retire_pc_o
);

    logic            dec_we;
    wb_pkg::wb_sel_t wb_sel;
    wb_pkg::xlen_t   pc_plus4;

    wb_ctrl wb_ctrl_inst (
        .inst_i   (wb_bundle_i.inst),
        .rf_we_o  (dec_we),
        .wb_sel_o (wb_sel)
    );

    // Return address for JAL and JALR
    assign pc_plus4 = wb_bundle_i.pc + wb_pkg::PC_STEP;

    // Write data select
    always_comb begin
        case (wb_sel)
            wb_pkg::WB_SEL_PC4:    rf_wdata_o = pc_plus4;
            wb_pkg::WB_SEL_RESULT: rf_wdata_o = wb_bundle_i.result;
            wb_pkg::WB_SEL_LOAD:   rf_wdata_o = wb_bundle_i.dmem_rdata;
            default:               rf_wdata_o = '0;
        endcase
    end

    // rd field
    assign rf_waddr_o = wb_bundle_i.inst[11:7];

    // The only place where valid gates the write
    assign rf_we_o = wb_valid_i & dec_we;

    // Every valid instruction retires, writing or not
    assign retire_o    = wb_valid_i;
    assign retire_pc_o = wb_bundle_i.pc;

endmodule

/* wbu/wb_ctrl.sv */
// Write-back control decode
module wb_ctrl (
    input  wb_pkg::xlen_t   inst_i,
    output logic            rf_we_o,
    output wb_pkg::wb_sel_t wb_sel_o
);

    wb_pkg::opcode_t opcode;

    assign opcode = inst_i[6:0];

    // Not qualified by valid, wbu masks the enable
    always_comb begin
        case (opcode)
            // Upper immediates and ALU ops take the ALU result
            wb_pkg::OPC_LUI,
            wb_pkg::OPC_AUIPC,
            wb_pkg::OPC_OP,
            wb_pkg::OPC_OP_IMM: begin
                rf_we_o  = 1'b1;
                wb_sel_o = wb_pkg::WB_SEL_RESULT;
            end

            // Loads write the data returned by memory
            wb_pkg::OPC_LOAD: begin
                rf_we_o  = 1'b1;
                wb_sel_o = wb_pkg::WB_SEL_LOAD;
            end

            // Jumps link the return address
            wb_pkg::OPC_JAL,
            wb_pkg::OPC_JALR: begin
                rf_we_o  = 1'b1;
                wb_sel_o = wb_pkg::WB_SEL_PC4;
            end

            // No destination register
            wb_pkg::OPC_STORE,
            wb_pkg::OPC_BRANCH,
            wb_pkg::OPC_SYSTEM: begin
                rf_we_o  = 1'b0;
                wb_sel_o = wb_pkg::WB_SEL_ZERO;
            end

            // Unknown opcodes retire without side effects
            default: begin
                rf_we_o  = 1'b0;
                wb_sel_o = wb_pkg::WB_SEL_ZERO;
            end
        endcase
    end

endmodule

/* rtl/mem_wb_latch.sv */
// Pipeline register between the memory stage and write-back
module mem_wb_latch (
    input  logic           clk,
    input  logic           rst_i,

    // From the memory stage
    input  logic           mem_valid_i,
    input  wb_pkg::mem_wb_t mem_bundle_i,

    // To the write-back unit
    output logic           wb_valid_o,
    output wb_pkg::mem_wb_t wb_bundle_o
);

    logic            valid_q;
    wb_pkg::mem_wb_t bundle_q;

    // Valid is sampled every cycle so it stays high for one cycle
    // per strobe, back-to-back strobes give a continuous level
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mem_valid_i;
        end
    end

    // Bundle only moves on a strobe, otherwise it holds
    always_ff @(posedge clk) begin
        if (rst_i) begin
            bundle_q <= '0;
        end else if (mem_valid_i) begin
            bundle_q <= mem_bundle_i;
        end
    end

    assign wb_valid_o  = valid_q;
    assign wb_bundle_o = bundle_q;

endmodule

/* common/wb_pkg.sv */
// Shared types and constants for the RV32I write-back end
package wb_pkg;

    // Data and address word
    typedef logic [31:0] xlen_t;

    // Architectural register number
    typedef logic [4:0] reg_addr_t;

    // Major opcode field, inst[6:0]
    typedef logic [6:0] opcode_t;

    // Write-back data source
    typedef logic [1:0] wb_sel_t;

    localparam wb_sel_t WB_SEL_ZERO   = 2'b00;
    localparam wb_sel_t WB_SEL_PC4    = 2'b01;
    localparam wb_sel_t WB_SEL_RESULT = 2'b10;
    localparam wb_sel_t WB_SEL_LOAD   = 2'b11;

    // Completed instruction handed over by the memory stage
    typedef struct packed {
        xlen_t pc;
        xlen_t inst;
        xlen_t result;
        xlen_t dmem_rdata;
    } mem_wb_t;

    // RV32I major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    // CSR and environment calls, no register write here
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // Link address offset
    localparam xlen_t PC_STEP = 32'd4;

endpackage
